// ==== sources.f ====
hw/stream_pkg.sv
hw/lane_fifo.sv
hw/packet_splitter.sv
hw/packet_merger.sv
hw/lane_stream_top.sv
dv/tb_lane_stream.sv

// ==== Makefile ====
VERILATOR   ?= verilator
TOP         ?= tb_lane_stream
RTL_TOP     ?= lane_stream_top
FILELIST    ?= sources.f
BUILD_DIR   ?= obj_dir
VFLAGS      ?= --binary --timing -Wno-fatal -j 0
LINT_FLAGS  ?= --lint-only -Wall --timing
PASS_MSG    ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/stream_testdata.hex ====
// One beat per line as five hex digits: {0, last, user[1:0]} then data[15:0]
// Packets of 3, 12, six single beats, 5 and 2 beats
11001
11002
51003
22A01
22A02
22A03
22A04
22A05
22A06
22A07
22A08
22A09
22A0A
22A0B
62A0C
43301
73302
53303
63304
43305
73306
3C0F1
3C0F2
3C0F3
3C0F4
7C0F5
0BEEF
4F00D

// ==== dv/tb_lane_stream.sv ====
`timescale 1ns/1ps

module tb_lane_stream
    import stream_pkg::*;
();

    localparam int NUM_BEATS    = 28;
    localparam int DRV_TIMEOUT  = 400;
    localparam int MON_TIMEOUT  = 400;
    localparam int STALL_LIMIT  = 60;
    localparam int STALL_HOLD   = 30;
    localparam int IDLE_WINDOW  = 16;
    localparam int READY_HIGH   = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_LOW    = 2;

    logic                     clk_i;
    logic                     reset_ni;
    logic                     s_valid_i;
    logic [STREAM_DATA_W-1:0] s_data_i;
    logic [STREAM_USER_W-1:0] s_user_i;
    logic                     s_last_i;
    logic                     s_ready_o;
    logic                     m_valid_o;
    logic [STREAM_DATA_W-1:0] m_data_o;
    logic [STREAM_USER_W-1:0] m_user_o;
    logic                     m_last_o;
    logic                     m_ready_i;

    // Each entry is {unused, last, user[1:0], data[15:0]}
    logic [19:0] beats [NUM_BEATS];
    logic [15:0] lfsr_state;
    int          ready_mode;
    int          error_count;
    int          timeout_count;
    string       test_name;

    lane_stream_top DUT (
        .clk_i     (clk_i),
        .reset_ni  (reset_ni),
        .s_valid_i (s_valid_i),
        .s_data_i  (s_data_i),
        .s_user_i  (s_user_i),
        .s_last_i  (s_last_i),
        .s_ready_o (s_ready_o),
        .m_valid_o (m_valid_o),
        .m_data_o  (m_data_o),
        .m_user_o  (m_user_o),
        .m_last_o  (m_last_o),
        .m_ready_i (m_ready_i)
    );

    always #50 clk_i = ~clk_i;

    // Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // Output ready follows the mode picked by the running phase
    always @(posedge clk_i) begin
        case (ready_mode)
            READY_HIGH: m_ready_i <= 1'b1;
            READY_LOW:  m_ready_i <= 1'b0;
            default: begin
                lfsr_state = lfsr_step(lfsr_state);
                m_ready_i <= lfsr_state[0];
            end
        endcase
    end

    // Mode changes land between edges so the ready driver sees them cleanly
    task automatic set_ready_mode(input int mode);
        @(negedge clk_i);
        ready_mode = mode;
    endtask

    task automatic present_beat(input int idx);
        s_valid_i <= 1'b1;
        s_data_i  <= beats[idx][15:0];
        s_user_i  <= beats[idx][17:16];
        s_last_i  <= beats[idx][18];
    endtask

    task automatic drive_beats();
        int idx;
        int wait_cnt;
        idx = 0;
        wait_cnt = 0;
        @(posedge clk_i);
        present_beat(0);
        while (idx < NUM_BEATS) begin
            @(posedge clk_i);
            if (s_ready_o) begin
                idx++;
                wait_cnt = 0;
                if (idx < NUM_BEATS) begin
                    present_beat(idx);
                end else begin
                    s_valid_i <= 1'b0;
                end
            end else begin
                wait_cnt++;
                if (wait_cnt > DRV_TIMEOUT) begin
                    timeout_count++;
                    $display("Timeout in %s: input beat %0d was not accepted within %0d cycles",
                             test_name, idx, DRV_TIMEOUT);
                    s_valid_i <= 1'b0;
                    break;
                end
            end
        end
    endtask

    task automatic collect_beats();
        int idx;
        int wait_cnt;
        logic [15:0] exp_data;
        logic [1:0]  exp_user;
        logic        exp_last;
        idx = 0;
        wait_cnt = 0;
        while (idx < NUM_BEATS) begin
            @(posedge clk_i);
            if (m_valid_o && m_ready_i) begin
                exp_data = beats[idx][15:0];
                exp_user = beats[idx][17:16];
                exp_last = beats[idx][18];
                assert (m_data_o == exp_data) else begin
                    error_count++;
                    $display("Mismatch in %s, beat %0d data: expected %h, actual %h",
                             test_name, idx, exp_data, m_data_o);
                end
                assert (m_user_o == exp_user) else begin
                    error_count++;
                    $display("Mismatch in %s, beat %0d user: expected %0d, actual %0d",
                             test_name, idx, exp_user, m_user_o);
                end
                assert (m_last_o == exp_last) else begin
                    error_count++;
                    $display("Mismatch in %s, beat %0d last: expected %0d, actual %0d",
                             test_name, idx, exp_last, m_last_o);
                end
                idx++;
                wait_cnt = 0;
            end else begin
                wait_cnt++;
                if (wait_cnt > MON_TIMEOUT) begin
                    timeout_count++;
                    $display("Timeout in %s: output beat %0d did not arrive within %0d cycles",
                             test_name, idx, MON_TIMEOUT);
                    break;
                end
            end
        end
    endtask

    // With every lane stalled the first long packet must fill its lane
    task automatic watch_stall();
        int   wait_cnt;
        logic fell;
        fell = 1'b0;
        for (wait_cnt = 0; wait_cnt < STALL_LIMIT && !fell; wait_cnt++) begin
            @(posedge clk_i);
            fell = !s_ready_o;
        end
        assert (fell) else begin
            error_count++;
            $display("Input ready stayed high for %0d cycles while the output was stalled",
                     STALL_LIMIT);
        end
        repeat (STALL_HOLD) @(posedge clk_i);
        set_ready_mode(READY_HIGH);
    endtask

    // Any leftover valid beat means something was duplicated
    task automatic check_idle();
        for (int i = 0; i < IDLE_WINDOW; i++) begin
            @(posedge clk_i);
            assert (!m_valid_o) else begin
                error_count++;
                $display("Extra output beat %h seen in %s after the whole sequence",
                         m_data_o, test_name);
            end
        end
    endtask

    task automatic run_phase(input string name, input int mode, input logic stall);
        merge_state_e st;
        test_name = name;
        set_ready_mode(mode);
        st = DUT.u_merger.state;
        $display("Starting %s with merger in %s", name, st.name());
        fork
            drive_beats();
            collect_beats();
            if (stall) watch_stall();
        join
        check_idle();
    endtask

    task automatic finish_run();
        $display("Checks failed: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    initial begin
        clk_i         = 1'b0;
        reset_ni      = 1'b0;
        s_valid_i     = 1'b0;
        s_data_i      = '0;
        s_user_i      = '0;
        s_last_i      = 1'b0;
        m_ready_i     = 1'b0;
        lfsr_state    = 16'd91;
        ready_mode    = READY_HIGH;
        error_count   = 0;
        timeout_count = 0;
        test_name     = "reset";
        $readmemh("dv/stream_testdata.hex", beats);
        assert (!$isunknown(beats[NUM_BEATS-1])) else begin
            error_count++;
            $display("Data file did not provide all %0d beats", NUM_BEATS);
        end

        repeat (2) @(posedge clk_i);
        reset_ni <= 1'b1;
        @(negedge clk_i);
        assert (!m_valid_o) else begin
            error_count++;
            $display("Output valid is high right after reset");
        end
        assert (s_ready_o) else begin
            error_count++;
            $display("Input ready is low right after reset");
        end

        run_phase("ready_high", READY_HIGH, 1'b0);
        if (timeout_count == 0) begin
            run_phase("random_ready", READY_RANDOM, 1'b0);
        end
        if (timeout_count == 0) begin
            run_phase("stall", READY_LOW, 1'b1);
        end
        finish_run();
    end

endmodule

// ==== hw/lane_stream_top.sv ====
`timescale 1ns/1ps

module lane_stream_top
    import stream_pkg::*;
#(
    parameter int DATA_WIDTH = STREAM_DATA_W,
    parameter int USER_WIDTH = STREAM_USER_W,
    parameter int NUM_LANES  = STREAM_LANES,
    parameter int LANE_DEPTH = STREAM_LANE_DEPTH
) (
    input  logic                  clk_i,
    input  logic                  reset_ni,

    input  logic                  s_valid_i,
    input  logic [DATA_WIDTH-1:0] s_data_i,
    input  logic [USER_WIDTH-1:0] s_user_i,
    input  logic                  s_last_i,
    output logic                  s_ready_o,

    output logic                  m_valid_o,
    output logic [DATA_WIDTH-1:0] m_data_o,
    output logic [USER_WIDTH-1:0] m_user_o,
    output logic                  m_last_o,
    input  logic                  m_ready_i
);

    // Write side, payload is shared by all lanes
    logic [NUM_LANES-1:0]            lane_in_valid;
    logic [NUM_LANES-1:0]            lane_in_full;
    logic [DATA_WIDTH-1:0]           lane_in_data;
    logic [USER_WIDTH-1:0]           lane_in_user;
    logic                            lane_in_last;

    // Read side, one slice per lane in flat vectors
    logic [NUM_LANES-1:0]            lane_out_valid;
    logic [NUM_LANES-1:0]            lane_out_ready;
    logic [NUM_LANES*DATA_WIDTH-1:0] lane_out_data;
    logic [NUM_LANES*USER_WIDTH-1:0] lane_out_user;
    logic [NUM_LANES-1:0]            lane_out_last;

    packet_splitter #(
        .DATA_WIDTH (DATA_WIDTH),
        .USER_WIDTH (USER_WIDTH),
        .NUM_LANES  (NUM_LANES)
    ) u_splitter (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .s_valid_i    (s_valid_i),
        .s_data_i     (s_data_i),
        .s_user_i     (s_user_i),
        .s_last_i     (s_last_i),
        .s_ready_o    (s_ready_o),
        .lane_full_i  (lane_in_full),
        .lane_valid_o (lane_in_valid),
        .lane_data_o  (lane_in_data),
        .lane_user_o  (lane_in_user),
        .lane_last_o  (lane_in_last)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        lane_fifo #(
            .DATA_WIDTH (DATA_WIDTH),
            .USER_WIDTH (USER_WIDTH),
            .DEPTH      (LANE_DEPTH)
        ) u_fifo (
            .clk_i       (clk_i),
            .reset_ni    (reset_ni),
            .in_valid_i  (lane_in_valid[g]),
            .in_data_i   (lane_in_data),
            .in_user_i   (lane_in_user),
            .in_last_i   (lane_in_last),
            .in_full_o   (lane_in_full[g]),
            .out_ready_i (lane_out_ready[g]),
            .out_valid_o (lane_out_valid[g]),
            .out_data_o  (lane_out_data[g*DATA_WIDTH +: DATA_WIDTH]),
            .out_user_o  (lane_out_user[g*USER_WIDTH +: USER_WIDTH]),
            .out_last_o  (lane_out_last[g])
        );
    end

    packet_merger #(
        .DATA_WIDTH (DATA_WIDTH),
        .USER_WIDTH (USER_WIDTH),
        .NUM_LANES  (NUM_LANES)
    ) u_merger (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .lane_valid_i (lane_out_valid),
        .lane_data_i  (lane_out_data),
        .lane_user_i  (lane_out_user),
        .lane_last_i  (lane_out_last),
        .lane_ready_o (lane_out_ready),
        .m_valid_o    (m_valid_o),
        .m_data_o     (m_data_o),
        .m_user_o     (m_user_o),
        .m_last_o     (m_last_o),
        .m_ready_i    (m_ready_i)
    );

endmodule

// ==== hw/packet_merger.sv ====
`timescale 1ns/1ps

module packet_merger
    import stream_pkg::*;
#(
    parameter int DATA_WIDTH = STREAM_DATA_W,
    parameter int USER_WIDTH = STREAM_USER_W,
    parameter int NUM_LANES  = STREAM_LANES
) (
    input  logic                            clk_i,
    input  logic                            reset_ni,

    input  logic [NUM_LANES-1:0]            lane_valid_i,
    input  logic [NUM_LANES*DATA_WIDTH-1:0] lane_data_i,
    input  logic [NUM_LANES*USER_WIDTH-1:0] lane_user_i,
    input  logic [NUM_LANES-1:0]            lane_last_i,
    output logic [NUM_LANES-1:0]            lane_ready_o,

    output logic                            m_valid_o,
    output logic [DATA_WIDTH-1:0]           m_data_o,
    output logic [USER_WIDTH-1:0]           m_user_o,
    output logic                            m_last_o,
    input  logic                            m_ready_i
);

    localparam int IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [IDX_W-1:0] lane_sel;
    merge_state_e     state;
    logic             xfer;

    // The output is a plain mux over the current lane, no extra register stage
    assign m_valid_o = lane_valid_i[lane_sel];
    assign m_data_o  = lane_data_i[lane_sel*DATA_WIDTH +: DATA_WIDTH];
    assign m_user_o  = lane_user_i[lane_sel*USER_WIDTH +: USER_WIDTH];
    assign m_last_o  = lane_last_i[lane_sel];

    assign xfer = m_valid_o && m_ready_i;

    // Other lanes keep their output registers and fill up behind them
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_ready_o[i] = m_ready_i && (lane_sel == IDX_W'(i));
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            lane_sel <= '0;
            state    <= MERGE_HUNT;
        end else if (xfer) begin
            if (m_last_o) begin
                // Packet done, follow the splitter to the next lane
                state <= MERGE_HUNT;
                if (lane_sel == IDX_W'(NUM_LANES - 1)) begin
                    lane_sel <= '0;
                end else begin
                    lane_sel <= lane_sel + 1'b1;
                end
            end else begin
                state <= MERGE_PASS;
            end
        end
    end

endmodule

// ==== hw/packet_splitter.sv ====
`timescale 1ns/1ps

module packet_splitter
    import stream_pkg::*;
#(
    parameter int DATA_WIDTH = STREAM_DATA_W,
    parameter int USER_WIDTH = STREAM_USER_W,
    parameter int NUM_LANES  = STREAM_LANES
) (
    input  logic                  clk_i,
    input  logic                  reset_ni,

    input  logic                  s_valid_i,
    input  logic [DATA_WIDTH-1:0] s_data_i,
    input  logic [USER_WIDTH-1:0] s_user_i,
    input  logic                  s_last_i,
    output logic                  s_ready_o,

    input  logic [NUM_LANES-1:0]  lane_full_i,
    output logic [NUM_LANES-1:0]  lane_valid_o,
    output logic [DATA_WIDTH-1:0] lane_data_o,
    output logic [USER_WIDTH-1:0] lane_user_o,
    output logic                  lane_last_o
);

    localparam int IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [IDX_W-1:0] lane_sel;
    logic             accept;

    // Only the selected lane's full flag can hold off the input
    assign s_ready_o = !lane_full_i[lane_sel];
    assign accept    = s_valid_i && s_ready_o;

    // Payload goes to every lane, the one-hot valid picks the writer
    assign lane_data_o = s_data_i;
    assign lane_user_o = s_user_i;
    assign lane_last_o = s_last_i;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_valid_o[i] = accept && (lane_sel == IDX_W'(i));
        end
    end

    // Whole packets stay on one lane, so move on only after the last beat
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            lane_sel <= '0;
        end else if (accept && s_last_i) begin
            if (lane_sel == IDX_W'(NUM_LANES - 1)) begin
                lane_sel <= '0;
            end else begin
                lane_sel <= lane_sel + 1'b1;
            end
        end
    end

endmodule

// ==== hw/lane_fifo.sv ====
`timescale 1ns/1ps

module lane_fifo
    import stream_pkg::*;
#(
    parameter int DATA_WIDTH = STREAM_DATA_W,
    parameter int USER_WIDTH = STREAM_USER_W,
    parameter int DEPTH      = STREAM_LANE_DEPTH
) (
    input  logic                  clk_i,
    input  logic                  reset_ni,

    input  logic                  in_valid_i,
    input  logic [DATA_WIDTH-1:0] in_data_i,
    input  logic [USER_WIDTH-1:0] in_user_i,
    input  logic                  in_last_i,
    output logic                  in_full_o,

    input  logic                  out_ready_i,
    output logic                  out_valid_o,
    output logic [DATA_WIDTH-1:0] out_data_o,
    output logic [USER_WIDTH-1:0] out_user_o,
    output logic                  out_last_o
);

    localparam int ADDR_W = $clog2(DEPTH);

    logic [DATA_WIDTH-1:0] mem_data [DEPTH];
    logic [USER_WIDTH-1:0] mem_user [DEPTH];
    logic [DEPTH-1:0]      mem_last;

    // Pointers carry one extra wrap bit so full and empty can be told apart
    logic [ADDR_W:0]   wr_ptr;
    logic [ADDR_W:0]   rd_ptr;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;
    logic              empty;
    logic              out_held;
    logic              load_out;

    assign wr_addr = wr_ptr[ADDR_W-1:0];
    assign rd_addr = rd_ptr[ADDR_W-1:0];
    assign empty   = (wr_ptr == rd_ptr);

    // Same address with a different wrap bit means the memory is full
    // The output register is not counted here
    assign in_full_o = (wr_addr == rd_addr) && (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]);

    // A beat sitting in the output register that the merger has not taken yet
    assign out_held = out_valid_o && !out_ready_i;

    // Refill the output stage whenever it is empty or being taken this cycle
    assign load_out = !empty && !out_held;

    // The splitter only raises valid when this lane has room
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr <= '0;
        end else if (in_valid_i) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            mem_data[wr_addr] <= in_data_i;
            mem_user[wr_addr] <= in_user_i;
            mem_last[wr_addr] <= in_last_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rd_ptr      <= '0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= !empty || out_held;
            if (load_out) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_out) begin
            out_data_o <= mem_data[rd_addr];
            out_user_o <= mem_user[rd_addr];
            out_last_o <= mem_last[rd_addr];
        end
    end

endmodule

// ==== hw/stream_pkg.sv ====
package stream_pkg;

    // Default beat payload width in bits
    parameter int STREAM_DATA_W = 16;

    // Default sideband width carried next to every beat
    parameter int STREAM_USER_W = 2;

    // Default number of parallel lanes between splitter and merger
    parameter int STREAM_LANES = 4;

    // Default FIFO depth per lane, must be a power of two
    parameter int STREAM_LANE_DEPTH = 8;

    // Merger position within the packet stream
    // MERGE_HUNT waits for the first beat of the next packet on the current lane
    // MERGE_PASS is inside a packet until its last beat leaves
    typedef enum logic {
        MERGE_HUNT = 1'b0,
        MERGE_PASS = 1'b1
    } merge_state_e;

endpackage
